//--- lb_consts.svh
// ~~~~~~~~~~~~~~~~~~~~
// local-bus hub sizes and timing constants
// ~~~~~~~~~~~~~~~~~~~~
`ifndef LB_CONSTS_SVH
`define LB_CONSTS_SVH

// bus widths
`define LB_AW 24
`define LB_DW 32

// 16 entries per FIFO
`define LB_FIFO_AW 4

// lbb_clk cycles from host strobe to response capture
`define LB_RDELAY 3

// register bank decodes only the low address bits
`define LB_REG_AW 4

// peer ports sharing the host bus
`define LB_NPORT 2

`endif

//--- lb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// local-bus hub types
// request and response words, port index
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

package lb_pkg;

  // request word, pushed through the request FIFO as is
  typedef struct packed {
    logic               rstb;   // read strobe
    logic               wstb;   // write strobe
    logic               ren;
    logic               wen;
    logic [`LB_AW-1:0]  addr;
    logic [`LB_DW-1:0]  wdata;
  } lb_req_t;

  // response word, one per transaction
  typedef struct packed {
    logic               rnw;    // set for reads
    logic [`LB_DW-1:0]  rdata;  // don't care on writes
  } lb_rsp_t;

  // index of a peer port
  typedef logic [$clog2(`LB_NPORT)-1:0] lb_port_t;

endpackage

//--- fifo_2c.sv
// ~~~~~~~~~~~~~~~~~~~~
// dual-clock FIFO, Gray pointers
// write pointer synchronized into the read domain
// ~~~~~~~~~~~~~~~~~~~~
module fifo_2c #(
  parameter int aw = 4,
  parameter int dw = 32
) (
  // write side
  input  logic          wr_clk,
  input  logic          wr_rst,
  input  logic          we,
  input  logic [dw-1:0] din,
  // read side
  input  logic          rd_clk,
  input  logic          rd_rst,
  input  logic          re,
  output logic [dw-1:0] dout,
  output logic          empty
);

  logic [dw-1:0] mem [2**aw];

  logic [aw:0] wr_bin;
  logic [aw:0] wr_bin_next;
  logic [aw:0] wr_gray;

  logic [aw:0] rd_bin;
  logic [aw:0] rd_bin_next;
  logic [aw:0] rd_gray;
  logic        rd_pop;

  logic [aw:0] wr_gray_s1;   // first sync stage
  logic [aw:0] wr_gray_s2;

  function automatic logic [aw:0] bin2gray(input logic [aw:0] b);
    return b ^ (b >> 1);
  endfunction

  // write domain
  assign wr_bin_next = wr_bin + 1'b1;

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[wr_bin[aw-1:0]] <= din;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (we) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= bin2gray(wr_bin_next);  // one bit changes per write
    end
  end

  // read domain
  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign empty       = (rd_gray == wr_gray_s2);
  assign rd_pop      = re & ~empty;   // ignore pops on empty
  assign rd_bin_next = rd_bin + 1'b1;

  always_ff @(posedge rd_clk) begin
    if (rd_rst) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_pop) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= bin2gray(rd_bin_next);
    end
  end

  // head of queue, no output register
  assign dout = mem[rd_bin[aw-1:0]];

endmodule

//--- lb_cdc.sv
// ~~~~~~~~~~~~~~~~~~~~
// local-bus bridge between a peripheral clock and lbb_clk
// request FIFO to the host, response FIFO back
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

module lb_cdc (
  // peripheral side
  input  logic               lba_clk,
  input  lb_pkg::lb_req_t    lba_req,
  input  logic               rsp_en,
  output lb_pkg::lb_rsp_t    lba_rsp,
  output logic               rsp_stb,
  // host side
  input  logic               lbb_clk,
  input  logic               rst,
  output logic               req,
  input  logic               grant,
  output lb_pkg::lb_req_t    lbb_req,
  input  logic [`LB_DW-1:0]  host_rdata
);
  import lb_pkg::*;

  localparam int REQ_W = $bits(lb_req_t);
  localparam int RSP_W = $bits(lb_rsp_t);

  // lba_clk domain
  logic    rst_meta;
  logic    rst_a;
  logic    a2b_we;
  logic    b2a_re;
  logic    b2a_empty;
  lb_rsp_t b2a_dout;

  // lbb_clk domain
  logic                  a2b_re;
  logic                  a2b_empty;
  lb_req_t               a2b_dout;
  logic                  busy;      // slot owned, response pending
  logic                  rnw_q;
  logic [`LB_RDELAY-1:0] tlatch_sr;
  logic                  tlatch;
  lb_rsp_t               b2a_din;

  // reset brought over from lbb_clk
  always_ff @(posedge lba_clk) begin
    rst_meta <= rst;
    rst_a    <= rst_meta;
  end

  assign a2b_we = lba_req.wstb | lba_req.rstb;

  // rsp_stb doubles as the popped-last-cycle flag
  assign b2a_re = ~b2a_empty & rsp_en & ~rsp_stb;

  always_ff @(posedge lba_clk) begin
    if (rst_a) begin
      rsp_stb <= 1'b0;
    end else begin
      rsp_stb <= b2a_re;
    end
  end

  always_ff @(posedge lba_clk) begin
    if (b2a_re) begin
      lba_rsp <= b2a_dout;
    end
  end

  // host side request and capture
  assign req    = ~a2b_empty & ~busy;
  assign a2b_re = grant & ~a2b_empty;   // pop on grant
  assign tlatch = tlatch_sr[`LB_RDELAY-1];

  always_ff @(posedge lbb_clk) begin
    if (rst) begin
      lbb_req   <= '0;
      busy      <= 1'b0;
      tlatch_sr <= '0;
    end else begin
      lbb_req   <= a2b_re ? a2b_dout : '0;   // one-cycle valid word
      tlatch_sr <= {tlatch_sr[`LB_RDELAY-2:0], lbb_req.rstb | lbb_req.wstb};
      if (a2b_re) begin
        busy <= 1'b1;
      end else if (tlatch) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge lbb_clk) begin
    if (lbb_req.rstb | lbb_req.wstb) begin
      rnw_q <= lbb_req.ren;
    end
  end

  assign b2a_din = '{rnw: rnw_q, rdata: host_rdata};

  fifo_2c #(
    .aw(`LB_FIFO_AW),
    .dw(REQ_W)
  ) fifo_a2b (
    .wr_clk (lba_clk),
    .wr_rst (rst_a),
    .we     (a2b_we),
    .din    (lba_req),
    .rd_clk (lbb_clk),
    .rd_rst (rst),
    .re     (a2b_re),
    .dout   (a2b_dout),
    .empty  (a2b_empty)
  );

  fifo_2c #(
    .aw(`LB_FIFO_AW),
    .dw(RSP_W)
  ) fifo_b2a (
    .wr_clk (lbb_clk),
    .wr_rst (rst),
    .we     (tlatch),
    .din    (b2a_din),
    .rd_clk (lba_clk),
    .rd_rst (rst_a),
    .re     (b2a_re),
    .dout   (b2a_dout),
    .empty  (b2a_empty)
  );

endmodule

//--- lb_arb.sv
// ~~~~~~~~~~~~~~~~~~~~
// round-robin host bus arbiter
// one grant per bus slot, muxes the owner's request
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

module lb_arb (
  input  logic                  lbb_clk,
  input  logic                  rst,
  input  logic [`LB_NPORT-1:0]  req,
  output logic [`LB_NPORT-1:0]  grant,
  input  lb_pkg::lb_req_t       port_req [`LB_NPORT],
  output lb_pkg::lb_req_t       host_req
);
  import lb_pkg::*;

  localparam int SLOT_W = $clog2(`LB_RDELAY + 1);

  logic [SLOT_W-1:0] slot_cnt;    // cycles left in current slot
  logic              slot_free;
  lb_port_t          last_owner;  // round-robin pointer
  lb_port_t          owner;       // bus mux select
  lb_port_t          pick;
  logic              pick_vld;
  logic              bus_vld;

  assign slot_free = (slot_cnt == '0);

  // search starts one past the last owner
  always_comb begin
    int idx;
    pick     = last_owner;
    pick_vld = 1'b0;
    for (int i = 1; i <= `LB_NPORT; i++) begin
      idx = int'(last_owner) + i;
      if (idx >= `LB_NPORT) begin
        idx = idx - `LB_NPORT;
      end
      if (!pick_vld && req[idx]) begin
        pick     = lb_port_t'(idx);
        pick_vld = 1'b1;
      end
    end
    grant = '0;
    if (pick_vld && slot_free) begin
      grant[pick] = 1'b1;
    end
  end

  always_ff @(posedge lbb_clk) begin
    if (rst) begin
      slot_cnt   <= '0;
      bus_vld    <= 1'b0;
      owner      <= '0;
      last_owner <= '0;
    end else begin
      bus_vld <= |grant;   // bridge word shows up next cycle
      if (|grant) begin
        slot_cnt <= SLOT_W'(`LB_RDELAY);
        owner    <= pick;
      end else if (!slot_free) begin
        slot_cnt <= slot_cnt - 1'b1;
      end
      if (bus_vld) begin
        last_owner <= owner;
      end
    end
  end

  assign host_req = bus_vld ? port_req[owner] : '0;

endmodule

//--- lb_regbank.sv
// ~~~~~~~~~~~~~~~~~~~~
// host register bank, read data two cycles after strobe
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

module lb_regbank (
  input  logic               lbb_clk,
  input  logic               rst,
  input  lb_pkg::lb_req_t    host_req,
  output logic [`LB_DW-1:0]  host_rdata
);

  localparam int NREG = 2 ** `LB_REG_AW;

  logic [`LB_DW-1:0]     regs [NREG];
  logic [`LB_REG_AW-1:0] idx;        // high address bits ignored
  logic                  do_wr;
  logic                  do_rd;
  logic                  rd_vld;
  logic [`LB_DW-1:0]     rd_stage;   // first pipeline stage

  assign idx   = host_req.addr[`LB_REG_AW-1:0];
  assign do_wr = host_req.wstb & host_req.wen;
  assign do_rd = host_req.rstb & host_req.ren;

  always_ff @(posedge lbb_clk) begin
    if (rst) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (do_wr) begin
      regs[idx] <= host_req.wdata;
    end
  end

  always_ff @(posedge lbb_clk) begin
    if (do_rd) begin
      rd_stage <= regs[idx];
    end
  end

  // second stage holds until the next read
  always_ff @(posedge lbb_clk) begin
    if (rst) begin
      rd_vld     <= 1'b0;
      host_rdata <= '0;
    end else begin
      rd_vld <= do_rd;
      if (rd_vld) begin
        host_rdata <= rd_stage;
      end
    end
  end

endmodule

//--- lb_hub.sv
// ~~~~~~~~~~~~~~~~~~~~
// local-bus hub top, two peer ports on one register bank
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

module lb_hub (
  input  logic             lbb_clk,
  input  logic             rst,
  input  logic             p0_clk,
  input  logic             p1_clk,
  input  lb_pkg::lb_req_t  p0_req,
  input  lb_pkg::lb_req_t  p1_req,
  input  logic             p0_rsp_en,
  input  logic             p1_rsp_en,
  output lb_pkg::lb_rsp_t  p0_rsp,
  output lb_pkg::lb_rsp_t  p1_rsp,
  output logic             p0_rsp_stb,
  output logic             p1_rsp_stb
);
  import lb_pkg::*;

  logic [`LB_NPORT-1:0] req;
  logic [`LB_NPORT-1:0] grant;
  lb_req_t              port_req [`LB_NPORT];  // per-bridge host words
  lb_req_t              host_req;
  logic [`LB_DW-1:0]    host_rdata;

  lb_cdc cdc0 (
    .lba_clk    (p0_clk),
    .lba_req    (p0_req),
    .rsp_en     (p0_rsp_en),
    .lba_rsp    (p0_rsp),
    .rsp_stb    (p0_rsp_stb),
    .lbb_clk    (lbb_clk),
    .rst        (rst),
    .req        (req[0]),
    .grant      (grant[0]),
    .lbb_req    (port_req[0]),
    .host_rdata (host_rdata)
  );

  lb_cdc cdc1 (
    .lba_clk    (p1_clk),
    .lba_req    (p1_req),
    .rsp_en     (p1_rsp_en),
    .lba_rsp    (p1_rsp),
    .rsp_stb    (p1_rsp_stb),
    .lbb_clk    (lbb_clk),
    .rst        (rst),
    .req        (req[1]),
    .grant      (grant[1]),
    .lbb_req    (port_req[1]),
    .host_rdata (host_rdata)
  );

  lb_arb arb (
    .lbb_clk  (lbb_clk),
    .rst      (rst),
    .req      (req),
    .grant    (grant),
    .port_req (port_req),
    .host_req (host_req)
  );

  lb_regbank regs (
    .lbb_clk    (lbb_clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_rdata (host_rdata)
  );

endmodule

//--- tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock source, 50% duty
// ~~~~~~~~~~~~~~~~~~~~
module tb_clk_gen #(
  parameter int period_ns = 10
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;   // even periods only
    end
  end

endmodule

//--- lb_hub_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// local-bus hub testbench, random traffic on both ports
// ~~~~~~~~~~~~~~~~~~~~
`include "lb_consts.svh"

module lb_hub_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lb_pkg::*;

  localparam int N_RAND  = 150;   // random transactions per port
  localparam int N_HOLD  = 6;
  localparam int MAX_OUT = 8;     // outstanding limit per port
  localparam int N_TXN   = 2 * (8 + 16 + N_RAND + N_HOLD);

  logic    lbb_clk;
  logic    p0_clk;
  logic    p1_clk;
  logic    rst;
  lb_req_t p0_req;
  lb_req_t p1_req;
  logic    p0_rsp_en;
  logic    p1_rsp_en;
  lb_rsp_t p0_rsp;
  lb_rsp_t p1_rsp;
  logic    p0_rsp_stb;
  logic    p1_rsp_stb;

  logic [`LB_DW-1:0] model [2**`LB_REG_AW];   // p0 owns 0-7, p1 owns 8-15
  lb_rsp_t           exp_q0 [$];
  lb_rsp_t           exp_q1 [$];
  int                issued [2];
  int                rcvd [2];
  logic              hold [2];                // responses held off
  string             test_name;

  tb_clk_gen #(.period_ns(10)) lbb_clk_gen (.clk(lbb_clk));
  tb_clk_gen #(.period_ns(14)) p0_clk_gen (.clk(p0_clk));
  tb_clk_gen #(.period_ns(6))  p1_clk_gen (.clk(p1_clk));

  lb_hub lb_hub_inst (
    .lbb_clk    (lbb_clk),
    .rst        (rst),
    .p0_clk     (p0_clk),
    .p1_clk     (p1_clk),
    .p0_req     (p0_req),
    .p1_req     (p1_req),
    .p0_rsp_en  (p0_rsp_en),
    .p1_rsp_en  (p1_rsp_en),
    .p0_rsp     (p0_rsp),
    .p1_rsp     (p1_rsp),
    .p0_rsp_stb (p0_rsp_stb),
    .p1_rsp_stb (p1_rsp_stb)
  );

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rsp(input string name, input lb_rsp_t exp, input lb_rsp_t got);
    if (got !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_rnw(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("MISMATCH %s rnw expected %b actual %b", name, exp, got);
      stop_run();
    end
  endtask

  task automatic port_edge(input lb_port_t port);
    if (port == 1'b0) begin
      @(posedge p0_clk);
    end else begin
      @(posedge p1_clk);
    end
  endtask

  task automatic set_rsp_en(input lb_port_t port, input logic en);
    port_edge(port);
    #1;
    if (port == 1'b0) begin
      p0_rsp_en = en;
    end else begin
      p1_rsp_en = en;
    end
  endtask

  // one-cycle strobe on the port's own clock
  task automatic drive_req(input lb_port_t port, input lb_req_t r);
    port_edge(port);
    #1;
    if (port == 1'b0) begin
      p0_req = r;
    end else begin
      p1_req = r;
    end
    port_edge(port);
    #1;
    if (port == 1'b0) begin
      p0_req = '0;
    end else begin
      p1_req = '0;
    end
  endtask

  task automatic issue_txn(input lb_port_t port, input logic wr, input logic [2:0] slot,
                           input logic [`LB_DW-1:0] data);
    lb_req_t               r;
    lb_rsp_t               e;
    logic [`LB_REG_AW-1:0] idx;
    logic [`LB_AW-1:0]     hi;
    while (issued[port] - rcvd[port] >= MAX_OUT) begin
      port_edge(port);
    end
    idx    = {port, slot};
    hi     = `LB_AW'($urandom());   // high bits alias onto the same word
    r      = '0;
    r.addr = {hi[`LB_AW-1:`LB_REG_AW], idx};
    if (wr) begin
      r.wstb     = 1'b1;
      r.wen      = 1'b1;
      r.wdata    = data;
      model[idx] = data;
      e.rnw      = 1'b0;
      e.rdata    = '0;
    end else begin
      r.rstb  = 1'b1;
      r.ren   = 1'b1;
      e.rnw   = 1'b1;
      e.rdata = model[idx];
    end
    if (port == 1'b0) begin
      exp_q0.push_back(e);
    end else begin
      exp_q1.push_back(e);
    end
    issued[port]++;
    drive_req(port, r);
  endtask

  task automatic wait_idle(input lb_port_t port);
    while (rcvd[port] != issued[port]) begin
      port_edge(port);
    end
  endtask

  task automatic take_rsp(input lb_port_t port, input lb_rsp_t got);
    lb_rsp_t e;
    int      n;
    n = (port == 1'b0) ? exp_q0.size() : exp_q1.size();
    if (hold[port]) begin
      $display("port %0d gave a response strobe while rsp_en was held low", port);
      stop_run();
    end else if (n == 0) begin
      $display("port %0d gave a response strobe with nothing outstanding", port);
      stop_run();
    end else begin
      if (port == 1'b0) begin
        e = exp_q0.pop_front();
      end else begin
        e = exp_q1.pop_front();
      end
      rcvd[port]++;
      if (e.rnw) begin
        check_rsp(test_name, e, got);
      end else begin
        check_rnw(test_name, e.rnw, got.rnw);   // write data not defined
      end
    end
  endtask

  task automatic reads_after_reset(input lb_port_t port);
    for (int i = 0; i < 8; i++) begin
      issue_txn(port, 1'b0, 3'(i), '0);
    end
    wait_idle(port);
  endtask

  task automatic write_readback(input lb_port_t port);
    logic [`LB_DW-1:0] d;
    for (int i = 0; i < 8; i++) begin
      d = $urandom();
      issue_txn(port, 1'b1, 3'(i), d);
      issue_txn(port, 1'b0, 3'(i), '0);
    end
    wait_idle(port);
  endtask

  task automatic random_traffic(input lb_port_t port, input int n);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd = $urandom();
      issue_txn(port, rnd[0], rnd[3:1], $urandom());
    end
    wait_idle(port);
  endtask

  task automatic rsp_holdoff(input lb_port_t port);
    set_rsp_en(port, 1'b0);
    hold[port] = 1'b1;
    for (int i = 0; i < N_HOLD; i++) begin
      issue_txn(port, i[0], 3'(i), $urandom());
    end
    repeat (200) begin
      port_edge(port);   // responses pile up in the FIFO
    end
    hold[port] = 1'b0;
    set_rsp_en(port, 1'b1);
    wait_idle(port);
  endtask

  initial begin
    fork
      forever begin
        @(negedge p0_clk);
        if (p0_rsp_stb === 1'b1) begin
          take_rsp(1'b0, p0_rsp);
        end
      end
      forever begin
        @(negedge p1_clk);
        if (p1_rsp_stb === 1'b1) begin
          take_rsp(1'b1, p1_rsp);
        end
      end
    join
  end

  // watchdog
  initial begin
    #(N_TXN * 400);
    $display("timeout after %0d ns, responses still missing", N_TXN * 400);
    stop_run();
  end

  initial begin
    void'($urandom(32'h0c19652a));
    rst       = 1'b1;
    p0_req    = '0;
    p1_req    = '0;
    p0_rsp_en = 1'b1;
    p1_rsp_en = 1'b1;
    test_name = "reset";
    for (int i = 0; i < 2; i++) begin
      issued[i] = 0;
      rcvd[i]   = 0;
      hold[i]   = 1'b0;
    end
    for (int i = 0; i < 2**`LB_REG_AW; i++) begin
      model[i] = '0;
    end
    repeat (4) begin
      @(posedge lbb_clk);
    end
    #1;
    rst = 1'b0;
    repeat (4) begin
      @(posedge p0_clk);   // bridge resets leave the port domains
    end

    test_name = "reads_after_reset";
    fork
      reads_after_reset(1'b0);
      reads_after_reset(1'b1);
    join
    test_name = "write_readback";
    fork
      write_readback(1'b0);
      write_readback(1'b1);
    join
    test_name = "random_traffic";
    fork
      random_traffic(1'b0, N_RAND);
      random_traffic(1'b1, N_RAND);
    join
    test_name = "rsp_holdoff";
    fork
      rsp_holdoff(1'b0);
      rsp_holdoff(1'b1);
    join

    test_name = "end_of_run";
    repeat (40) begin
      @(posedge lbb_clk);   // quiet bus, a stray strobe still gets caught
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      $display("responses missing at end of run, p0 %0d p1 %0d",
               exp_q0.size(), exp_q1.size());
      stop_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+.
lb_pkg.sv
fifo_2c.sv
lb_cdc.sv
lb_arb.sv
lb_regbank.sv
lb_hub.sv
tb_clk_gen.sv
lb_hub_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lb_hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module lb_hub_tb -f verilog.f -o lb_hub_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lb_hub_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
